/* logic/sched_config.svh */
//--------------------------------------
// GEMM tile scheduler widths and limits
//--------------------------------------
`ifndef SCHED_CONFIG_SVH
`define SCHED_CONFIG_SVH

// Width of M, N and the m/n tile counts and indices
`define SCHED_M_W 10

// K runs deeper than M and N, so it gets more bits
`define SCHED_K_W 12

// Tile sizes Tm, Tn, Tk and the in-slice k index
`define SCHED_T_W 5

// Largest Tm or Tn the array accepts
// Also the row and column mask width
`define SCHED_MAX_T 16

// Buffer address width, 1024 entries per bank
`define SCHED_ADDR_W 10

`endif

/* logic/sched_dims_pkg.sv */
//--------------------------------------
// Scheduler dimension types
//--------------------------------------
`default_nettype none

`include "sched_config.svh"

package sched_dims_pkg;

  // Problem sizes and tile indices in M and N
  typedef logic [`SCHED_M_W-1:0] dim_mn_t;
  // Problem size and tile index along K
  typedef logic [`SCHED_K_W-1:0] dim_k_t;
  // Tile extent, also used for the k index inside a slice
  typedef logic [`SCHED_T_W-1:0] tile_sz_t;
  // One enable bit per PE row or column
  typedef logic [`SCHED_MAX_T-1:0] lane_mask_t;
  typedef logic [31:0] perf_cnt_t;
  typedef logic [`SCHED_ADDR_W-1:0] buf_addr_t;

  // Job descriptor from the host
  // Tile counts are precomputed ceilings, never derived in hardware
  typedef struct packed {
    dim_mn_t  m;
    dim_mn_t  n;
    dim_k_t   k;
    tile_sz_t tm;
    tile_sz_t tn;
    tile_sz_t tk;
    dim_mn_t  mt;
    dim_mn_t  nt;
    dim_k_t   kt;
  } sched_cfg_t;

  // Current position in the (m, n, k) loop
  typedef struct packed {
    dim_mn_t m_tile;
    dim_mn_t n_tile;
    dim_k_t  k_tile;
  } tile_pos_t;

endpackage

`default_nettype wire

/* logic/sched_ctrl_pkg.sv */
//--------------------------------------
// Scheduler control types
//--------------------------------------
`default_nettype none

package sched_ctrl_pkg;

  import sched_dims_pkg::*;

  // One-hot FSM encoding
  // Each state decodes from a single bit
  typedef enum logic [6:0] {
    IDLE        = 7'b000_0001,
    PREP_TILE   = 7'b000_0010,
    WAIT_READY  = 7'b000_0100,
    LOAD_WEIGHT = 7'b000_1000,
    STREAM_K    = 7'b001_0000,
    TILE_DONE   = 7'b010_0000,
    DONE        = 7'b100_0000
  } sched_state_t;

  // Bank fill status from the DMA, all levels
  // Ping holds even k tiles, pong holds odd ones
  typedef struct packed {
    logic a_ping;
    logic a_pong;
    logic b_ping;
    logic b_pong;
  } bank_valid_t;

  // Read command to the A and B buffers
  typedef struct packed {
    logic      rd_en;
    // Position inside the current k slice
    tile_sz_t  k_idx;
    // Valid in the weight load phase only
    buf_addr_t wgt_addr;
    // Valid in the activation stream phase only
    buf_addr_t act_addr;
    // 0 for ping, 1 for pong, shared by A and B
    logic      bank_sel;
  } buf_rd_t;

endpackage

`default_nettype wire

/* logic/sched_cmd_capture.sv */
//--------------------------------------
// Start latch and config capture
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sched_cmd_capture
  import sched_dims_pkg::*;
  import sched_ctrl_pkg::*;
(
  input  wire         clk_gated,
  input  wire         rst_n,
  input  wire         start,
  input  wire         abort,
  input  sched_cfg_t  cfg,
  input  bank_valid_t bank_valid,
  input  wire         bank_sel,
  input  wire         leave_idle,
  output logic        go,
  output sched_cfg_t  cfg_q,
  output logic        banks_ready
);

  logic start_q;

  //--------------------------------------
  // Start latch
  //--------------------------------------
  // Holds a start pulse until the FSM takes it
  // Clearing wins over a start in the same cycle
  always_ff @(posedge clk_gated or negedge rst_n) begin
    if (!rst_n) begin
      start_q <= 1'b0;
    end else if (abort || leave_idle) begin
      start_q <= 1'b0;
    end else if (start) begin
      start_q <= 1'b1;
    end
  end

  assign go = start_q;

  // Job snapshot on start
  // Host may reprogram cfg while this job runs
  always_ff @(posedge clk_gated or negedge rst_n) begin
    if (!rst_n) begin
      cfg_q <= '0;
    end else if (start) begin
      cfg_q <= cfg;
    end
  end

  //--------------------------------------
  // Bank readiness
  //--------------------------------------
  // k tile parity picks ping or pong
  // Both A and B of that bank must be filled
  always_comb begin
    if (bank_sel) begin
      banks_ready = bank_valid.a_pong & bank_valid.b_pong;
    end else begin
      banks_ready = bank_valid.a_ping & bank_valid.b_ping;
    end
  end

endmodule

`default_nettype wire

/* logic/tile_sequencer.sv */
//--------------------------------------
// Tile loop FSM and read sequencing
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tile_sequencer
  import sched_dims_pkg::*;
  import sched_ctrl_pkg::*;
(
  input  wire          clk_gated,
  input  wire          rst_n,
  input  wire          abort,
  input  wire          go,
  input  wire          start,
  input  sched_cfg_t   cfg_q,
  input  wire          banks_ready,
  input  tile_sz_t     tk_eff,
  output tile_pos_t    pos,
  output buf_rd_t      rd_cmd,
  output logic         clr,
  output logic         load_weight,
  output logic         en,
  output logic         done_tile,
  output logic         busy,
  output logic         leave_idle,
  output sched_state_t state,
  output logic         bank_sel
);

  sched_state_t state_d;
  // Step inside the current k slice
  tile_sz_t     k_ctr;
  logic         k_last;
  logic         last_k;
  logic         last_n;
  logic         last_m;

  // End of slice and end of loop flags
  assign k_last = (k_ctr == tk_eff - tile_sz_t'(1));
  assign last_k = (pos.k_tile == cfg_q.kt - dim_k_t'(1));
  assign last_n = (pos.n_tile == cfg_q.nt - dim_mn_t'(1));
  assign last_m = (pos.m_tile == cfg_q.mt - dim_mn_t'(1));

  //--------------------------------------
  // Next state
  //--------------------------------------
  always_comb begin
    state_d = state;
    case (state)
      IDLE: begin
        if (go) begin
          state_d = PREP_TILE;
        end
      end
      // Single cycle, accumulators cleared
      PREP_TILE: state_d = WAIT_READY;
      // DMA back-pressure, hold here until both banks fill
      WAIT_READY: begin
        if (banks_ready) begin
          state_d = LOAD_WEIGHT;
        end
      end
      LOAD_WEIGHT: begin
        if (k_last) begin
          state_d = STREAM_K;
        end
      end
      // Next k slice or close the output tile
      STREAM_K: begin
        if (k_last) begin
          state_d = last_k ? TILE_DONE : WAIT_READY;
        end
      end
      TILE_DONE: state_d = (last_m && last_n) ? DONE : PREP_TILE;
      // Raw start restarts at once, no pass through IDLE
      DONE: begin
        if (start) begin
          state_d = PREP_TILE;
        end
      end
      default: state_d = IDLE;
    endcase
    if (abort) begin
      state_d = IDLE;
    end
  end

  always_ff @(posedge clk_gated or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= state_d;
    end
  end

  //--------------------------------------
  // Tile indices and k counter
  //--------------------------------------
  always_ff @(posedge clk_gated or negedge rst_n) begin
    if (!rst_n) begin
      pos   <= '0;
      k_ctr <= '0;
    end else if (abort) begin
      pos   <= '0;
      k_ctr <= '0;
    end else begin
      case (state)
        PREP_TILE: begin
          pos.k_tile <= '0;
          k_ctr      <= '0;
        end
        // Same count runs twice per slice, once per phase
        LOAD_WEIGHT: k_ctr <= k_last ? tile_sz_t'(0) : k_ctr + tile_sz_t'(1);
        STREAM_K: begin
          k_ctr <= k_last ? tile_sz_t'(0) : k_ctr + tile_sz_t'(1);
          // Parity flip moves reads to the other bank
          if (k_last && !last_k) begin
            pos.k_tile <= pos.k_tile + dim_k_t'(1);
          end
        end
        TILE_DONE: begin
          // k back to 0 so a new job never starts past its own KT
          pos.k_tile <= '0;
          // Row-major walk, n fastest
          if (last_n) begin
            pos.n_tile <= '0;
            pos.m_tile <= last_m ? dim_mn_t'(0) : pos.m_tile + dim_mn_t'(1);
          end else begin
            pos.n_tile <= pos.n_tile + dim_mn_t'(1);
          end
        end
        default: ;
      endcase
    end
  end

  //--------------------------------------
  // Buffer reads and array controls
  //--------------------------------------
  assign bank_sel = pos.k_tile[0];

  always_comb begin
    rd_cmd          = '0;
    rd_cmd.bank_sel = bank_sel;
    if (state == LOAD_WEIGHT) begin
      rd_cmd.rd_en    = 1'b1;
      rd_cmd.k_idx    = k_ctr;
      rd_cmd.wgt_addr = buf_addr_t'(k_ctr);
    end else if (state == STREAM_K) begin
      rd_cmd.rd_en    = 1'b1;
      rd_cmd.k_idx    = k_ctr;
      rd_cmd.act_addr = buf_addr_t'(k_ctr);
    end
  end

  assign clr        = (state == PREP_TILE);
  assign en         = (state == STREAM_K);
  assign done_tile  = (state == TILE_DONE);
  assign busy       = !(state inside {IDLE, DONE});
  assign leave_idle = ((state == IDLE) && go) || ((state == DONE) && start);

  // Weight data arrives one cycle after its read
  always_ff @(posedge clk_gated or negedge rst_n) begin
    if (!rst_n) begin
      load_weight <= 1'b0;
    end else begin
      load_weight <= (state == LOAD_WEIGHT);
    end
  end

  //--------------------------------------
  // Checks
  //--------------------------------------
  a_state_legal: assert property (@(posedge clk_gated) disable iff (!rst_n)
    state inside {IDLE, PREP_TILE, WAIT_READY, LOAD_WEIGHT, STREAM_K, TILE_DONE, DONE})
    else $error("state %b is not a legal encoding", state);

  // k index stays inside the edge-clamped slice
  a_kidx_range: assert property (@(posedge clk_gated) disable iff (!rst_n)
    rd_cmd.rd_en |-> (rd_cmd.k_idx < tk_eff))
    else $error("k_idx %0d not below tk_eff %0d", rd_cmd.k_idx, tk_eff);

  a_ktile_range: assert property (@(posedge clk_gated) disable iff (!rst_n)
    busy |-> (pos.k_tile < cfg_q.kt))
    else $error("k_tile %0d not below kt %0d", pos.k_tile, cfg_q.kt);

endmodule

`default_nettype wire

/* logic/tile_edge_mask.sv */
//--------------------------------------
// Edge tile sizes and lane masks
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "sched_config.svh"

module tile_edge_mask
  import sched_dims_pkg::*;
(
  input  sched_cfg_t cfg_q,
  input  tile_pos_t  pos,
  output lane_mask_t row_mask,
  output lane_mask_t col_mask,
  output tile_sz_t   tk_eff
);

  // Wide enough for any index times tile size
  typedef logic [`SCHED_K_W+`SCHED_T_W-1:0] ext_t;

  tile_sz_t tm_eff;
  tile_sz_t tn_eff;

  // Remaining extent past this tile's offset, clamped to the tile size
  function automatic tile_sz_t eff_size(input dim_k_t dim, input dim_k_t idx,
                                        input tile_sz_t tsz);
    ext_t off;
    ext_t rem;
    off = ext_t'(idx) * ext_t'(tsz);
    rem = (ext_t'(dim) > off) ? ext_t'(dim) - off : ext_t'(0);
    return (rem > ext_t'(tsz)) ? tsz : tile_sz_t'(rem);
  endfunction

  // Low cnt bits set, LSB is lane 0
  function automatic lane_mask_t low_mask(input tile_sz_t cnt);
    lane_mask_t mask;
    mask = '0;
    for (int i = 0; i < `SCHED_MAX_T; i++) begin
      if (i < int'(cnt)) begin
        mask[i] = 1'b1;
      end
    end
    return mask;
  endfunction

  // M and N widen to the K width so one helper covers all three
  assign tm_eff = eff_size(dim_k_t'(cfg_q.m), dim_k_t'(pos.m_tile), cfg_q.tm);
  assign tn_eff = eff_size(dim_k_t'(cfg_q.n), dim_k_t'(pos.n_tile), cfg_q.tn);
  assign tk_eff = eff_size(cfg_q.k, pos.k_tile, cfg_q.tk);

  assign row_mask = low_mask(tm_eff);
  assign col_mask = low_mask(tn_eff);

  // Tiles wider than the array would drop lanes from the mask
  always_comb begin
    a_tile_fits: assert ((cfg_q.tm <= `SCHED_MAX_T) && (cfg_q.tn <= `SCHED_MAX_T))
      else $error("tile %0dx%0d exceeds array size", cfg_q.tm, cfg_q.tn);
  end

endmodule

`default_nettype wire

/* logic/sched_perf_counters.sv */
//--------------------------------------
// Per-tile performance counters
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sched_perf_counters
  import sched_dims_pkg::*;
  import sched_ctrl_pkg::*;
(
  input  wire          clk_gated,
  input  wire          rst_n,
  input  sched_state_t state,
  output perf_cnt_t    cycles_tile,
  output perf_cnt_t    stall_cycles
);

  // Restart at each tile, values hold after TILE_DONE for readout
  always_ff @(posedge clk_gated or negedge rst_n) begin
    if (!rst_n) begin
      cycles_tile  <= '0;
      stall_cycles <= '0;
    end else begin
      case (state)
        PREP_TILE: begin
          cycles_tile  <= '0;
          stall_cycles <= '0;
        end
        // Compute cycles, MACs enabled
        STREAM_K: cycles_tile <= cycles_tile + perf_cnt_t'(1);
        // Waiting on DMA to fill a bank
        WAIT_READY: stall_cycles <= stall_cycles + perf_cnt_t'(1);
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/gemm_tile_scheduler.sv */
//--------------------------------------
// GEMM tile scheduler top
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

module gemm_tile_scheduler
  import sched_dims_pkg::*;
  import sched_ctrl_pkg::*;
(
  input  wire         clk_gated,
  input  wire         rst_n,
  input  wire         start,
  input  wire         abort,
  input  sched_cfg_t  cfg,
  input  bank_valid_t bank_valid,
  output buf_rd_t     rd_cmd,
  output logic        clr,
  output logic        load_weight,
  output logic        en,
  output logic        done_tile,
  output logic        busy,
  output lane_mask_t  row_mask,
  output lane_mask_t  col_mask,
  output tile_pos_t   pos,
  output perf_cnt_t   cycles_tile,
  output perf_cnt_t   stall_cycles
);

  //--------------------------------------
  // Internal links
  //--------------------------------------
  logic         go;
  sched_cfg_t   cfg_q;
  logic         banks_ready;
  // Ping/pong select back from the k tile parity
  logic         bank_sel;
  logic         leave_idle;
  tile_sz_t     tk_eff;
  sched_state_t state;

  // Host side, start and job snapshot
  sched_cmd_capture sched_cmd_capture_inst (
    .clk_gated   (clk_gated),
    .rst_n       (rst_n),
    .start       (start),
    .abort       (abort),
    .cfg         (cfg),
    .bank_valid  (bank_valid),
    .bank_sel    (bank_sel),
    .leave_idle  (leave_idle),
    .go          (go),
    .cfg_q       (cfg_q),
    .banks_ready (banks_ready)
  );

  tile_sequencer tile_sequencer_inst (
    .clk_gated   (clk_gated),
    .rst_n       (rst_n),
    .abort       (abort),
    .go          (go),
    .start       (start),
    .cfg_q       (cfg_q),
    .banks_ready (banks_ready),
    .tk_eff      (tk_eff),
    .pos         (pos),
    .rd_cmd      (rd_cmd),
    .clr         (clr),
    .load_weight (load_weight),
    .en          (en),
    .done_tile   (done_tile),
    .busy        (busy),
    .leave_idle  (leave_idle),
    .state       (state),
    .bank_sel    (bank_sel)
  );

  // Edge clamping for the current position
  tile_edge_mask tile_edge_mask_inst (
    .cfg_q    (cfg_q),
    .pos      (pos),
    .row_mask (row_mask),
    .col_mask (col_mask),
    .tk_eff   (tk_eff)
  );

  sched_perf_counters sched_perf_counters_inst (
    .clk_gated    (clk_gated),
    .rst_n        (rst_n),
    .state        (state),
    .cycles_tile  (cycles_tile),
    .stall_cycles (stall_cycles)
  );

endmodule

`default_nettype wire

/* verif/tb_gemm_tile_scheduler.sv */
//--------------------------------------
// GEMM tile scheduler testbench
//--------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "sched_config.svh"

module tb_gemm_tile_scheduler
  import sched_dims_pkg::*;
  import sched_ctrl_pkg::*;
();

  localparam int          NUM_JOBS   = 6;
  // Job that gets cut short by abort
  localparam int          ABORT_JOB  = 2;
  localparam logic [31:0] LFSR_SEED  = 32'hed205fb4;
  localparam logic [31:0] LFSR_TAPS  = 32'h80200003;
  // Worst case of 8x8x8 tiles per job and 2*Tmax+40 cycles per slice
  localparam longint      WATCHDOG_CYCLES = longint'(NUM_JOBS) * 512 * (2 * `SCHED_MAX_T + 40);

  logic        clk_gated;
  logic        rst_n;
  logic        start;
  logic        abort;
  sched_cfg_t  cfg;
  bank_valid_t bank_valid;
  buf_rd_t     rd_cmd;
  logic        clr;
  logic        load_weight;
  logic        en;
  logic        done_tile;
  logic        busy;
  lane_mask_t  row_mask;
  lane_mask_t  col_mask;
  tile_pos_t   pos;
  perf_cnt_t   cycles_tile;
  perf_cnt_t   stall_cycles;

  logic [31:0] lfsr = LFSR_SEED;
  sched_cfg_t  jobs [NUM_JOBS];
  // Job the DUT is running as the testbench sent it
  sched_cfg_t  cur_cfg = '0;
  int          errors = 0;
  int          jobs_done = 0;
  int          tiles_total = 0;
  int          slices_total = 0;

  // Reference model state owned by the monitor
  int exp_m = 0;
  int exp_n = 0;
  int exp_k = 0;
  int clr_cnt = 0;
  int done_cnt = 0;
  int load_run = 0;
  int stream_run = 0;
  int tk_sum = 0;
  int tile_busy = 0;
  int tk_exp = 0;
  bit idle_due = 1'b0;
  logic [3:0] flips;

  gemm_tile_scheduler gemm_tile_scheduler_inst (
    .clk_gated    (clk_gated),
    .rst_n        (rst_n),
    .start        (start),
    .abort        (abort),
    .cfg          (cfg),
    .bank_valid   (bank_valid),
    .rd_cmd       (rd_cmd),
    .clr          (clr),
    .load_weight  (load_weight),
    .en           (en),
    .done_tile    (done_tile),
    .busy         (busy),
    .row_mask     (row_mask),
    .col_mask     (col_mask),
    .pos          (pos),
    .cycles_tile  (cycles_tile),
    .stall_cycles (stall_cycles)
  );

  initial begin
    clk_gated = 1'b0;
    forever #4 clk_gated = ~clk_gated;
  end

  //--------------------------------------
  // Helpers
  //--------------------------------------
  task automatic log_mismatch(input string name, input longint expected, input longint actual);
    errors++;
    $display("FAILED t=%0t %s expected %0d actual %0d", $time, name, expected, actual);
  endtask

  task automatic fail_check(input string what);
    errors++;
    $display("Error at t=%0t: %s", $time, what);
  endtask

  task automatic print_summary();
    $display("Summary: %0d jobs, %0d tiles, %0d slices checked, %0d errors",
             jobs_done, tiles_total, slices_total, errors);
  endtask

  // Galois LFSR stepped once per bit taken
  function automatic int unsigned rand_bits(input int n);
    int unsigned val;
    val = 0;
    for (int i = 0; i < n; i++) begin
      val  = (val << 1) | int'(lfsr[0]);
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
    end
    return val;
  endfunction

  // Effective slice depth min(Tk, K - k*Tk)
  function automatic int slice_len(input int k);
    int rem;
    rem = int'(cur_cfg.k) - k * int'(cur_cfg.tk);
    return (rem > int'(cur_cfg.tk)) ? int'(cur_cfg.tk) : rem;
  endfunction

  // Low min(tsz, dim - idx*tsz) bits set
  function automatic lane_mask_t edge_mask(input int dim, input int idx, input int tsz);
    int rem;
    lane_mask_t mask;
    rem = dim - idx * tsz;
    if (rem > tsz) begin
      rem = tsz;
    end
    mask = '0;
    for (int i = 0; i < rem; i++) begin
      mask[i] = 1'b1;
    end
    return mask;
  endfunction

  // Tile counts as host-side ceilings
  task automatic build_job(output sched_cfg_t c, input int m, input int n, input int k,
                           input int tm, input int tn, input int tk);
    c.m  = dim_mn_t'(m);
    c.n  = dim_mn_t'(n);
    c.k  = dim_k_t'(k);
    c.tm = tile_sz_t'(tm);
    c.tn = tile_sz_t'(tn);
    c.tk = tile_sz_t'(tk);
    c.mt = dim_mn_t'((m + tm - 1) / tm);
    c.nt = dim_mn_t'((n + tn - 1) / tn);
    c.kt = dim_k_t'((k + tk - 1) / tk);
  endtask

  //--------------------------------------
  // Bank valids from a mock DMA
  //--------------------------------------
  // Each valid flips with probability 1/4 per cycle
  always @(posedge clk_gated) begin
    if (rst_n) begin
      for (int i = 0; i < 4; i++) begin
        flips[i] = (rand_bits(2) == 3);
      end
      bank_valid <= bank_valid ^ flips;
    end
  end

  //--------------------------------------
  // Concurrent checks
  //--------------------------------------
  // Selected bank pair was filled the cycle before the first read
  a_bank_ready: assert property (@(posedge clk_gated) disable iff (!rst_n)
    (rd_cmd.rd_en && !$past(rd_cmd.rd_en)) |->
      (rd_cmd.bank_sel ? ($past(bank_valid.a_pong) && $past(bank_valid.b_pong))
                       : ($past(bank_valid.a_ping) && $past(bank_valid.b_ping))))
    else fail_check("slice read started on a bank that was not valid");

  a_load_weight: assert property (@(posedge clk_gated) disable iff (!rst_n)
    load_weight == $past(rd_cmd.rd_en && !en))
    else log_mismatch("load_weight", !$sampled(load_weight), $sampled(load_weight));

  a_row_mask: assert property (@(posedge clk_gated) disable iff (!rst_n)
    busy |-> (row_mask == edge_mask(cur_cfg.m, pos.m_tile, cur_cfg.tm)))
    else log_mismatch("row_mask", edge_mask(cur_cfg.m, $sampled(pos.m_tile), cur_cfg.tm),
                      $sampled(row_mask));

  a_col_mask: assert property (@(posedge clk_gated) disable iff (!rst_n)
    busy |-> (col_mask == edge_mask(cur_cfg.n, pos.n_tile, cur_cfg.tn)))
    else log_mismatch("col_mask", edge_mask(cur_cfg.n, $sampled(pos.n_tile), cur_cfg.tn),
                      $sampled(col_mask));

  a_abort: assert property (@(posedge clk_gated) disable iff (!rst_n)
    (abort && busy) |=> (!busy && (pos == tile_pos_t'(0))))
    else fail_check("abort did not drop busy and clear pos one cycle later");

  //--------------------------------------
  // Reference model monitor
  //--------------------------------------
  always @(posedge clk_gated) begin
    if (rst_n) begin
      // New job restarts the walk at tile (0,0)
      if (start && !busy) begin
        exp_m    = 0;
        exp_n    = 0;
        clr_cnt  = 0;
        done_cnt = 0;
      end
      if (idle_due) begin
        assert (!busy) else fail_check("busy still high after the last done_tile");
        idle_due = 1'b0;
      end
      if (clr) begin
        assert (int'(pos.m_tile) == exp_m) else log_mismatch("pos.m_tile", exp_m, pos.m_tile);
        assert (int'(pos.n_tile) == exp_n) else log_mismatch("pos.n_tile", exp_n, pos.n_tile);
        assert (pos.k_tile == '0) else log_mismatch("pos.k_tile", 0, pos.k_tile);
        clr_cnt++;
        tile_busy  = 1;
        tk_sum     = 0;
        load_run   = 0;
        stream_run = 0;
        exp_k      = 0;
      end else if (done_tile) begin
        assert (exp_k == int'(cur_cfg.kt)) else log_mismatch("k slices", cur_cfg.kt, exp_k);
        assert (int'(pos.m_tile) == exp_m) else log_mismatch("pos.m_tile", exp_m, pos.m_tile);
        assert (int'(pos.n_tile) == exp_n) else log_mismatch("pos.n_tile", exp_n, pos.n_tile);
        assert (cycles_tile == perf_cnt_t'(tk_sum))
          else log_mismatch("cycles_tile", tk_sum, cycles_tile);
        // Busy time minus clr and the load and stream phases
        assert (stall_cycles == perf_cnt_t'(tile_busy - 1 - 2 * tk_sum))
          else log_mismatch("stall_cycles", tile_busy - 1 - 2 * tk_sum, stall_cycles);
        done_cnt++;
        tiles_total++;
        if (exp_n == int'(cur_cfg.nt) - 1) begin
          exp_n = 0;
          if (exp_m == int'(cur_cfg.mt) - 1) begin
            idle_due = 1'b1;
          end
          exp_m++;
        end else begin
          exp_n++;
        end
      end else if (busy) begin
        tile_busy++;
      end

      // Weight load phase
      if (rd_cmd.rd_en && !en) begin
        tk_exp = slice_len(exp_k);
        assert (load_run < tk_exp) else fail_check("weight load ran past tk_eff");
        assert (int'(pos.k_tile) == exp_k) else log_mismatch("pos.k_tile", exp_k, pos.k_tile);
        assert (rd_cmd.bank_sel == exp_k[0])
          else log_mismatch("rd_cmd.bank_sel", exp_k % 2, rd_cmd.bank_sel);
        assert (int'(rd_cmd.k_idx) == load_run)
          else log_mismatch("rd_cmd.k_idx", load_run, rd_cmd.k_idx);
        assert (int'(rd_cmd.wgt_addr) == load_run)
          else log_mismatch("rd_cmd.wgt_addr", load_run, rd_cmd.wgt_addr);
        load_run++;
      end

      // Activation stream phase
      if (en) begin
        tk_exp = slice_len(exp_k);
        assert (rd_cmd.rd_en) else fail_check("en high without a buffer read");
        assert (load_run == tk_exp) else log_mismatch("weight load length", tk_exp, load_run);
        assert (rd_cmd.bank_sel == exp_k[0])
          else log_mismatch("rd_cmd.bank_sel", exp_k % 2, rd_cmd.bank_sel);
        assert (int'(rd_cmd.k_idx) == stream_run)
          else log_mismatch("rd_cmd.k_idx", stream_run, rd_cmd.k_idx);
        assert (int'(rd_cmd.act_addr) == stream_run)
          else log_mismatch("rd_cmd.act_addr", stream_run, rd_cmd.act_addr);
        stream_run++;
        // Slice complete so the next one reads the other bank
        if (stream_run == tk_exp) begin
          tk_sum += tk_exp;
          exp_k++;
          slices_total++;
          load_run   = 0;
          stream_run = 0;
        end
      end
    end
  end

  //--------------------------------------
  // Stimulus
  //--------------------------------------
  task automatic run_job(input int idx, input bit cut_short);
    int tiles;
    @(posedge clk_gated);
    cur_cfg = jobs[idx];
    cfg   <= jobs[idx];
    start <= 1'b1;
    @(posedge clk_gated);
    start <= 1'b0;
    tiles = int'(jobs[idx].mt) * int'(jobs[idx].nt);
    if (cut_short) begin
      // Abort in the middle of the first stream phase
      while (!en) @(posedge clk_gated);
      abort <= 1'b1;
      @(posedge clk_gated);
      abort <= 1'b0;
      repeat (4) @(posedge clk_gated);
    end else begin
      while (!busy) @(posedge clk_gated);
      while (busy) @(posedge clk_gated);
      @(posedge clk_gated);
      assert (clr_cnt == tiles) else log_mismatch("clr pulses", tiles, clr_cnt);
      assert (done_cnt == tiles) else log_mismatch("done_tile pulses", tiles, done_cnt);
      jobs_done++;
    end
  endtask

  initial begin
    rst_n      = 1'b0;
    start      = 1'b0;
    abort      = 1'b0;
    cfg        = '0;
    bank_valid = '0;
    // Fixed job with edge tiles in all three dimensions
    build_job(jobs[0], 37, 21, 33, 8, 16, 7);
    // Sizes 1..40 and tiles 5..16 give at most 8 tiles per dimension
    for (int j = 1; j < NUM_JOBS; j++) begin
      build_job(jobs[j], rand_bits(6) % 40 + 1, rand_bits(6) % 40 + 1,
                rand_bits(6) % 40 + 1, rand_bits(4) % 12 + 5,
                rand_bits(4) % 12 + 5, rand_bits(4) % 12 + 5);
    end
    repeat (8) @(posedge clk_gated);
    rst_n <= 1'b1;
    for (int j = 0; j < NUM_JOBS; j++) begin
      run_job(j, j == ABORT_JOB);
    end
    print_summary();
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // Hang guard
  initial begin
    repeat (WATCHDOG_CYCLES + 8) @(posedge clk_gated);
    $display("Error: watchdog expired before all jobs finished");
    print_summary();
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+logic
logic/sched_dims_pkg.sv
logic/sched_ctrl_pkg.sv
logic/sched_cmd_capture.sv
logic/tile_sequencer.sv
logic/tile_edge_mask.sv
logic/sched_perf_counters.sv
logic/gemm_tile_scheduler.sv
verif/tb_gemm_tile_scheduler.sv

/* run.sh */
#!/bin/sh
# Build and run the GEMM tile scheduler testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log &&
verilator --binary --timing --assert -Wno-fatal -f project.f \
  --top-module tb_gemm_tile_scheduler -o sim_tb > build.log 2>&1 ||
  { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
# The log decides pass or fail
grep -qx "TESTS PASSED" sim.log && echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }
